//--- source/coreTypes.sv
package coreTypes;

    localparam int xlen = 32; // The opcodes below assume RV32.

    // ##################################################
    // Integer opcodes
    // ##################################################

    typedef enum logic [5:0] {
        INT_ADD = 6'd0,
        INT_SUB,
        INT_XOR,
        INT_OR,
        INT_AND,
        INT_SLL,
        INT_SRL,
        INT_SRA,
        INT_SLT,
        INT_SLTU,
        INT_LUI,
        INT_AUIPC,
        INT_MAX,
        INT_MAXU,
        INT_MIN,
        INT_MINU,
        INT_SH1ADD,
        INT_SH2ADD,
        INT_SH3ADD,
        INT_ANDN,
        INT_ORN,
        INT_XNOR,
        INT_SE_B,
        INT_SE_H,
        INT_ZE_H,
        INT_CLZ,
        INT_CTZ,
        INT_CPOP,
        INT_ORC_B,
        INT_REV8,
        INT_FSGNJ_S,
        INT_FSGNJN_S,
        INT_FSGNJX_S,
        // Conditional branches and jumps.
        INT_BEQ,
        INT_BNE,
        INT_BLT,
        INT_BGE,
        INT_BLTU,
        INT_BGEU,
        INT_JAL,
        INT_V_JR,
        INT_V_JALR,
        INT_V_RET,
        INT_SYS,
        // Atomics stay at the end so one compare finds them.
        ATOMIC_AMOADD_W,
        ATOMIC_AMOXOR_W,
        ATOMIC_AMOOR_W,
        ATOMIC_AMOAND_W,
        ATOMIC_AMOMAX_W,
        ATOMIC_AMOMAXU_W,
        ATOMIC_AMOMIN_W,
        ATOMIC_AMOMINU_W
    } IntOp;

    // ##################################################
    // Result flags
    // ##################################################

    typedef enum logic [3:0] {
        FLAGS_NONE = 4'd0,
        FLAGS_BRANCH,       // Branch that was not predicted.
        FLAGS_PRED_TAKEN,
        FLAGS_PRED_NTAKEN,
        // System codes, taken from the low bits of the SYS immediate.
        FLAGS_FENCE,
        FLAGS_ORDERING,
        FLAGS_XRET,
        FLAGS_TRAP,
        FLAGS_ILLEGAL_INSTR,
        FLAGS_EXCEPT,
        FLAGS_MEM_MISALIGN,
        FLAGS_ACCESS_FAULT,
        FLAGS_BREAKPOINT,
        FLAGS_ENV_CALL,
        FLAGS_WFI,
        FLAGS_RESERVED
    } Flags;

endpackage

//--- source/leadZeroCount.sv
`timescale 1ns/1ps

module leadZeroCount (
    input  logic [coreTypes::xlen-1:0] in,
    output logic [5:0]                 out
);

    // Scan upwards so the highest set bit writes last and wins.
    always_comb begin
        out = 6'd32;
        for (int i = 0; i < coreTypes::xlen; i++) begin
            if (in[i]) begin
                out = 6'(coreTypes::xlen - 1 - i);
            end
        end
    end

endmodule

//--- source/popCount.sv
`timescale 1ns/1ps

module popCount (
    input  logic [coreTypes::xlen-1:0] in,
    output logic [5:0]                 out
);

    logic [1:0] sum1 [16];
    logic [2:0] sum2 [8];
    logic [3:0] sum3 [4];
    logic [4:0] sum4 [2];

    // Each level adds neighbouring pairs and grows by one bit.
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum1[i] = {1'b0, in[2*i]} + {1'b0, in[2*i+1]};
        end
        for (int i = 0; i < 8; i++) begin
            sum2[i] = {1'b0, sum1[2*i]} + {1'b0, sum1[2*i+1]};
        end
        for (int i = 0; i < 4; i++) begin
            sum3[i] = {1'b0, sum2[2*i]} + {1'b0, sum2[2*i+1]};
        end
        for (int i = 0; i < 2; i++) begin
            sum4[i] = {1'b0, sum3[2*i]} + {1'b0, sum3[2*i+1]};
        end
        out = {1'b0, sum4[0]} + {1'b0, sum4[1]};
    end

endmodule

//--- source/intAlu.sv
`timescale 1ns/1ps

module intAlu #(
    parameter int tagBits = 7,
    parameter int sqnBits = 7,
    parameter int histBits = 8,
    parameter int retIdxBits = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic                      uopValid,
    input  coreTypes::IntOp           opcode,
    input  logic [coreTypes::xlen-1:0] srcA,
    input  logic [coreTypes::xlen-1:0] srcB,
    input  logic [coreTypes::xlen-1:0] imm,
    input  logic [coreTypes::xlen-1:0] pc,
    input  logic                      compressed,
    input  logic [tagBits-1:0]        tagDst,
    input  logic [sqnBits-1:0]        sqN,
    input  logic [sqnBits-1:0]        storeSqN,
    input  logic [histBits-1:0]       history,
    input  logic                      predValid,
    input  logic                      predTaken,
    input  logic [retIdxBits-1:0]     retIdx,
    input  logic                      en,
    input  logic                      wbStall,
    input  logic                      invalidate,
    input  logic [sqnBits-1:0]        invalidateSqN,

    output logic                      wbReq,
    output logic                      fwdValid,
    output logic [tagBits-1:0]        fwdTag,
    output logic [coreTypes::xlen-1:0] fwdResult,

    output logic                      resValid,
    output logic [coreTypes::xlen-1:0] resResult,
    output logic [tagBits-1:0]        resTag,
    output logic [sqnBits-1:0]        resSqN,
    output logic [sqnBits-1:0]        resStoreSqN,
    output coreTypes::Flags           resFlags,
    output logic                      resNoCommit,

    output logic                      brTaken,
    output logic [coreTypes::xlen-1:0] brDstPC,
    output logic [sqnBits-1:0]        brSqN,
    output logic [histBits-1:0]       brHistory,
    output logic [retIdxBits-1:0]     brRetIdx,

    output logic                      btValid,
    output logic [coreTypes::xlen-1:0] btSrc,
    output logic [coreTypes::xlen-1:0] btDst,
    output logic                      btIsJump,
    output logic                      btIsCall,
    output logic                      btCompressed
);

    logic                       accept;
    logic [sqnBits-1:0]         sqnDelta;
    logic [coreTypes::xlen-1:0] result;
    coreTypes::Flags            flags;
    logic [coreTypes::xlen-1:0] srcARev;
    logic [5:0]                 lzCount;
    logic [5:0]                 ones;
    logic                       lessThan;
    logic                       lessThanU;
    logic [coreTypes::xlen-1:0] pcPlus2;
    logic [coreTypes::xlen-1:0] pcPlus4;
    logic [coreTypes::xlen-1:0] fallThrough;
    logic [coreTypes::xlen-1:0] branchTarget;
    logic [coreTypes::xlen-1:0] indDst;
    logic [coreTypes::xlen-1:0] dstPC;
    logic                       isBranch;
    logic                       isIndirect;
    logic                       branchTaken;
    logic                       redirect;
    logic                       btUpdate;
    logic                       btIsJumpNext;
    logic                       btIsCallNext;
    logic [retIdxBits-1:0]      retIdxNext;
    logic [histBits-1:0]        historyNext;

    // A uop younger than the flush point is dropped.
    assign sqnDelta = sqN - invalidateSqN;
    assign accept = uopValid && en && !wbStall && (!invalidate || $signed(sqnDelta) <= 0);

    assign wbReq = uopValid && en;
    assign fwdValid = uopValid && en && !tagDst[tagBits-1];
    assign fwdTag = tagDst;
    assign fwdResult = result;

    // ##################################################
    // Result selection
    // ##################################################

    assign srcARev = {<<{srcA}}; // CTZ is CLZ of the reversed operand.

    leadZeroCount lzc0 (
        .in  (opcode == coreTypes::INT_CLZ ? srcA : srcARev),
        .out (lzCount)
    );

    popCount popc0 (
        .in  (srcA),
        .out (ones)
    );

    assign lessThan = $signed(srcA) < $signed(srcB);
    assign lessThanU = srcA < srcB;
    assign pcPlus2 = pc + 32'd2;
    assign pcPlus4 = pc + 32'd4;
    assign fallThrough = compressed ? pcPlus2 : pcPlus4;

    always_comb begin
        case (opcode)
            coreTypes::INT_AUIPC: result = pc + imm;
            coreTypes::INT_LUI: result = srcB;
            coreTypes::ATOMIC_AMOADD_W, coreTypes::INT_ADD: result = srcA + srcB;
            coreTypes::ATOMIC_AMOXOR_W, coreTypes::INT_XOR: result = srcA ^ srcB;
            coreTypes::ATOMIC_AMOOR_W, coreTypes::INT_OR: result = srcA | srcB;
            coreTypes::ATOMIC_AMOAND_W, coreTypes::INT_AND: result = srcA & srcB;
            coreTypes::ATOMIC_AMOMAX_W, coreTypes::INT_MAX: result = lessThan ? srcB : srcA;
            coreTypes::ATOMIC_AMOMAXU_W, coreTypes::INT_MAXU: result = lessThanU ? srcB : srcA;
            coreTypes::ATOMIC_AMOMIN_W, coreTypes::INT_MIN: result = lessThan ? srcA : srcB;
            coreTypes::ATOMIC_AMOMINU_W, coreTypes::INT_MINU: result = lessThanU ? srcA : srcB;
            coreTypes::INT_SUB: result = srcA - srcB;
            coreTypes::INT_SLL: result = srcA << srcB[4:0];
            coreTypes::INT_SRL: result = srcA >> srcB[4:0];
            coreTypes::INT_SRA: result = $signed(srcA) >>> srcB[4:0];
            coreTypes::INT_SLT: result = {31'b0, lessThan};
            coreTypes::INT_SLTU: result = {31'b0, lessThanU};
            coreTypes::INT_JAL,
            coreTypes::INT_V_JR,
            coreTypes::INT_V_JALR,
            coreTypes::INT_V_RET: result = fallThrough; // Link address.
            coreTypes::INT_SH1ADD: result = srcB + (srcA << 1);
            coreTypes::INT_SH2ADD: result = srcB + (srcA << 2);
            coreTypes::INT_SH3ADD: result = srcB + (srcA << 3);
            coreTypes::INT_ANDN: result = srcA & ~srcB;
            coreTypes::INT_ORN: result = srcA | ~srcB;
            coreTypes::INT_XNOR: result = srcA ^ ~srcB;
            coreTypes::INT_SE_B: result = {{24{srcA[7]}}, srcA[7:0]};
            coreTypes::INT_SE_H: result = {{16{srcA[15]}}, srcA[15:0]};
            coreTypes::INT_ZE_H: result = {16'b0, srcA[15:0]};
            coreTypes::INT_CLZ, coreTypes::INT_CTZ: result = {26'b0, lzCount};
            coreTypes::INT_CPOP: result = {26'b0, ones};
            coreTypes::INT_ORC_B: result = {{8{|srcA[31:24]}}, {8{|srcA[23:16]}},
                                            {8{|srcA[15:8]}}, {8{|srcA[7:0]}}};
            coreTypes::INT_REV8: result = {srcA[7:0], srcA[15:8], srcA[23:16], srcA[31:24]};
            coreTypes::INT_FSGNJ_S: result = {srcB[31], srcA[30:0]};
            coreTypes::INT_FSGNJN_S: result = {~srcB[31], srcA[30:0]};
            coreTypes::INT_FSGNJX_S: result = {srcA[31] ^ srcB[31], srcA[30:0]};
            default: result = '0;
        endcase
    end

    // ##################################################
    // Branch and jump resolution
    // ##################################################

    assign isBranch = opcode inside {coreTypes::INT_BEQ, coreTypes::INT_BNE,
                                     coreTypes::INT_BLT, coreTypes::INT_BGE,
                                     coreTypes::INT_BLTU, coreTypes::INT_BGEU};
    assign isIndirect = opcode inside {coreTypes::INT_V_JR, coreTypes::INT_V_JALR,
                                       coreTypes::INT_V_RET};

    always_comb begin
        case (opcode)
            coreTypes::INT_BEQ: branchTaken = srcA == srcB;
            coreTypes::INT_BNE: branchTaken = srcA != srcB;
            coreTypes::INT_BLT: branchTaken = lessThan;
            coreTypes::INT_BGE: branchTaken = !lessThan;
            coreTypes::INT_BLTU: branchTaken = lessThanU;
            coreTypes::INT_BGEU: branchTaken = !lessThanU;
            default: branchTaken = 1'b0;
        endcase
    end

    assign branchTarget = pc + {{(coreTypes::xlen-13){imm[12]}}, imm[12:0]};
    assign historyNext = isBranch ? {history[histBits-2:0], branchTaken} : history;

    always_comb begin
        if (opcode == coreTypes::INT_V_RET) begin
            indDst = srcA;
        end else begin
            indDst = srcA + {{(coreTypes::xlen-12){imm[11]}}, imm[11:0]};
        end
        indDst[0] = 1'b0;
    end

    always_comb begin
        redirect = 1'b0;
        btUpdate = 1'b0;
        dstPC = fallThrough;
        btIsJumpNext = 1'b0;
        btIsCallNext = 1'b0;
        retIdxNext = retIdx;
        if (isBranch) begin
            btUpdate = branchTaken && !predValid; // Target was unknown to the BTB.
            redirect = branchTaken != predTaken;
            if (branchTaken) begin
                dstPC = branchTarget;
            end
        end else if (isIndirect) begin
            // srcB holds the predicted target.
            redirect = indDst[31:1] != srcB[31:1];
            dstPC = indDst;
            btIsJumpNext = 1'b1;
            btIsCallNext = opcode == coreTypes::INT_V_JALR;
            if (redirect) begin
                if (opcode == coreTypes::INT_V_RET) begin
                    retIdxNext = retIdx - 1'b1;
                end else if (opcode == coreTypes::INT_V_JALR) begin
                    retIdxNext = retIdx + 1'b1;
                end
                btUpdate = opcode != coreTypes::INT_V_RET;
            end
        end
    end

    always_comb begin
        if (isBranch && predValid) begin
            flags = branchTaken ? coreTypes::FLAGS_PRED_TAKEN : coreTypes::FLAGS_PRED_NTAKEN;
        end else if (isBranch) begin
            flags = coreTypes::FLAGS_BRANCH;
        end else if (opcode == coreTypes::INT_SYS) begin
            flags = coreTypes::Flags'(imm[3:0]);
        end else begin
            flags = coreTypes::FLAGS_NONE;
        end
    end

    // ##################################################
    // Output registers
    // ##################################################

    always_ff @(posedge clk) begin
        if (!rst) begin
            resValid <= 1'b0;
            brTaken <= 1'b0;
            btValid <= 1'b0;
        end else begin
            resValid <= accept;
            brTaken <= accept && redirect;
            btValid <= accept && btUpdate;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resResult <= result;
            resTag <= tagDst;
            resSqN <= sqN;
            resStoreSqN <= storeSqN;
            resFlags <= flags;
            resNoCommit <= opcode >= coreTypes::ATOMIC_AMOADD_W; // Store port commits atomics.
            brDstPC <= dstPC;
            brSqN <= sqN;
            brHistory <= historyNext;
            brRetIdx <= retIdxNext;
            // Uncompressed branches are looked up by their second halfword.
            btSrc <= compressed ? pc : pcPlus2;
            btDst <= dstPC;
            btIsJump <= btIsJumpNext;
            btIsCall <= btIsCallNext;
            btCompressed <= compressed;
        end
    end

endmodule

//--- source/intExecPort.sv
`timescale 1ns/1ps

module intExecPort #(
    parameter int tagBits = 7,
    parameter int sqnBits = 7,
    parameter int histBits = 8,
    parameter int retIdxBits = 4
) (
    input  logic clk,
    input  logic rst,

    input  logic                      uopValid,
    input  coreTypes::IntOp           opcode,
    input  logic [coreTypes::xlen-1:0] srcA,
    input  logic [coreTypes::xlen-1:0] srcB,
    input  logic [coreTypes::xlen-1:0] imm,
    input  logic [coreTypes::xlen-1:0] pc,
    input  logic                      compressed,
    input  logic [tagBits-1:0]        tagDst,
    input  logic [sqnBits-1:0]        sqN,
    input  logic [sqnBits-1:0]        storeSqN,
    input  logic [histBits-1:0]       history,
    input  logic                      predValid,
    input  logic                      predTaken,
    input  logic [retIdxBits-1:0]     retIdx,
    input  logic                      en,
    input  logic                      wbStall,
    input  logic                      invalidate,
    input  logic [sqnBits-1:0]        invalidateSqN,

    output logic                      wbReq,
    output logic                      fwdValid,
    output logic [tagBits-1:0]        fwdTag,
    output logic [coreTypes::xlen-1:0] fwdResult,

    output logic                      resValid,
    output logic [coreTypes::xlen-1:0] resResult,
    output logic [tagBits-1:0]        resTag,
    output logic [sqnBits-1:0]        resSqN,
    output logic [sqnBits-1:0]        resStoreSqN,
    output coreTypes::Flags           resFlags,
    output logic                      resNoCommit,

    output logic                      brTaken,
    output logic [coreTypes::xlen-1:0] brDstPC,
    output logic [sqnBits-1:0]        brSqN,
    output logic [histBits-1:0]       brHistory,
    output logic [retIdxBits-1:0]     brRetIdx,

    output logic                      btValid,
    output logic [coreTypes::xlen-1:0] btSrc,
    output logic [coreTypes::xlen-1:0] btDst,
    output logic                      btIsJump,
    output logic                      btIsCall,
    output logic                      btCompressed
);

    // Single integer ALU behind the issue port.
    intAlu #(
        .tagBits    (tagBits),
        .sqnBits    (sqnBits),
        .histBits   (histBits),
        .retIdxBits (retIdxBits)
    ) alu0 (
        .clk           (clk),
        .rst           (rst),
        .uopValid      (uopValid),
        .opcode        (opcode),
        .srcA          (srcA),
        .srcB          (srcB),
        .imm           (imm),
        .pc            (pc),
        .compressed    (compressed),
        .tagDst        (tagDst),
        .sqN           (sqN),
        .storeSqN      (storeSqN),
        .history       (history),
        .predValid     (predValid),
        .predTaken     (predTaken),
        .retIdx        (retIdx),
        .en            (en),
        .wbStall       (wbStall),
        .invalidate    (invalidate),
        .invalidateSqN (invalidateSqN),
        .wbReq         (wbReq),
        .fwdValid      (fwdValid),
        .fwdTag        (fwdTag),
        .fwdResult     (fwdResult),
        .resValid      (resValid),
        .resResult     (resResult),
        .resTag        (resTag),
        .resSqN        (resSqN),
        .resStoreSqN   (resStoreSqN),
        .resFlags      (resFlags),
        .resNoCommit   (resNoCommit),
        .brTaken       (brTaken),
        .brDstPC       (brDstPC),
        .brSqN         (brSqN),
        .brHistory     (brHistory),
        .brRetIdx      (brRetIdx),
        .btValid       (btValid),
        .btSrc         (btSrc),
        .btDst         (btDst),
        .btIsJump      (btIsJump),
        .btIsCall      (btIsCall),
        .btCompressed  (btCompressed)
    );

endmodule

//--- sim/intExecTb_assert.sv
`timescale 1ns/1ps

module intExecTb_assert #(
    parameter int tagBits = 7,
    parameter int sqnBits = 7,
    parameter int histBits = 8,
    parameter int retIdxBits = 4
) (
    input logic clk, rst, uopValid, compressed, predValid, predTaken, en, wbStall, invalidate,
    input coreTypes::IntOp opcode,
    input logic [31:0] srcA, srcB, imm, pc,
    input logic [tagBits-1:0] tagDst,
    input logic [sqnBits-1:0] sqN, storeSqN, invalidateSqN,
    input logic [histBits-1:0] history,
    input logic [retIdxBits-1:0] retIdx,
    input logic wbReq, fwdValid, resValid, resNoCommit, brTaken, btValid,
    input logic btIsJump, btIsCall, btCompressed,
    input logic [tagBits-1:0] fwdTag, resTag,
    input logic [31:0] fwdResult, resResult, brDstPC, btSrc, btDst,
    input logic [sqnBits-1:0] resSqN, resStoreSqN, brSqN,
    input coreTypes::Flags resFlags,
    input logic [histBits-1:0] brHistory,
    input logic [retIdxBits-1:0] brRetIdx
);

    int errCount = 0;

    logic [sqnBits-1:0] diff;
    logic mAccept, mCheck, mBranch, mJump, mTaken, mRedirect, mBt, mNoCommit, mCall;
    logic [31:0] link, mResult, mDst, actual;
    logic [3:0] mFlags;
    logic [histBits-1:0] mHist;
    logic [retIdxBits-1:0] mRetIdx;

    logic expValid, expBr, expBt, expCheck, expNoCommit, expCall, expJump, expComp;
    logic [31:0] expResult, expDst, expSrc;
    logic [tagBits-1:0] expTag;
    logic [sqnBits-1:0] expSqN, expStoreSqN;
    logic [3:0] expFlags;
    logic [histBits-1:0] expHist;
    logic [retIdxBits-1:0] expRetIdx;

    function automatic logic [31:0] countBits(input logic [31:0] v);
        logic [31:0] n;
        n = 0;
        for (int i = 0; i < 32; i++) n = n + v[i];
        return n;
    endfunction

    function automatic logic [31:0] leading(input logic [31:0] v, input logic fromTop);
        logic [31:0] n;
        logic done;
        n = 0;
        done = 0;
        for (int i = 0; i < 32; i++) begin
            if (!done && v[fromTop ? 31 - i : i]) done = 1;
            else if (!done) n = n + 1;
        end
        return n;
    endfunction

    function automatic logic [31:0] refResult(input coreTypes::IntOp op,
                                              input logic [31:0] a, b, i, p, lnk);
        logic [31:0] r;
        logic lt, ltu;
        lt = $signed(a) < $signed(b);
        ltu = a < b;
        r = '0;
        case (op)
            coreTypes::INT_ADD, coreTypes::ATOMIC_AMOADD_W: r = a + b;
            coreTypes::INT_SUB: r = a - b;
            coreTypes::INT_XOR, coreTypes::ATOMIC_AMOXOR_W: r = a ^ b;
            coreTypes::INT_OR, coreTypes::ATOMIC_AMOOR_W: r = a | b;
            coreTypes::INT_AND, coreTypes::ATOMIC_AMOAND_W: r = a & b;
            coreTypes::INT_SLL: r = a << b[4:0];
            coreTypes::INT_SRL: r = a >> b[4:0];
            coreTypes::INT_SRA: r = 32'($signed(a) >>> b[4:0]);
            coreTypes::INT_SLT: r = {31'b0, lt};
            coreTypes::INT_SLTU: r = {31'b0, ltu};
            coreTypes::INT_LUI: r = b;
            coreTypes::INT_AUIPC: r = p + i;
            coreTypes::INT_MAX, coreTypes::ATOMIC_AMOMAX_W: r = lt ? b : a;
            coreTypes::INT_MAXU, coreTypes::ATOMIC_AMOMAXU_W: r = ltu ? b : a;
            coreTypes::INT_MIN, coreTypes::ATOMIC_AMOMIN_W: r = lt ? a : b;
            coreTypes::INT_MINU, coreTypes::ATOMIC_AMOMINU_W: r = ltu ? a : b;
            coreTypes::INT_SH1ADD: r = b + a * 2;
            coreTypes::INT_SH2ADD: r = b + a * 4;
            coreTypes::INT_SH3ADD: r = b + a * 8;
            coreTypes::INT_ANDN: r = a & ~b;
            coreTypes::INT_ORN: r = a | ~b;
            coreTypes::INT_XNOR: r = ~(a ^ b);
            coreTypes::INT_SE_B: r = 32'($signed(a[7:0]));
            coreTypes::INT_SE_H: r = 32'($signed(a[15:0]));
            coreTypes::INT_ZE_H: r = a & 32'h0000_ffff;
            coreTypes::INT_CLZ: r = leading(a, 1'b1);
            coreTypes::INT_CTZ: r = leading(a, 1'b0);
            coreTypes::INT_CPOP: r = countBits(a);
            coreTypes::INT_ORC_B: begin
                for (int k = 0; k < 4; k++) r[8*k +: 8] = (a[8*k +: 8] != 0) ? 8'hff : 8'h00;
            end
            coreTypes::INT_REV8: begin
                for (int k = 0; k < 4; k++) r[8*k +: 8] = a[8*(3-k) +: 8];
            end
            coreTypes::INT_FSGNJ_S: r = {b[31], a[30:0]};
            coreTypes::INT_FSGNJN_S: r = {!b[31], a[30:0]};
            coreTypes::INT_FSGNJX_S: r = {a[31] != b[31], a[30:0]};
            coreTypes::INT_JAL, coreTypes::INT_V_JR, coreTypes::INT_V_JALR,
            coreTypes::INT_V_RET: r = lnk;
            default: r = '0;
        endcase
        return r;
    endfunction

    // ##################################################
    // Reference model
    // ##################################################

    always_comb begin
        diff = sqN - invalidateSqN;
        mAccept = uopValid && en && !wbStall && (!invalidate || diff == '0 || diff[sqnBits-1]);
        link = pc + (compressed ? 32'd2 : 32'd4);
        mResult = refResult(opcode, srcA, srcB, imm, pc, link);
        mBranch = opcode >= coreTypes::INT_BEQ && opcode <= coreTypes::INT_BGEU;
        mJump = opcode inside {coreTypes::INT_V_JR, coreTypes::INT_V_JALR, coreTypes::INT_V_RET};
        mCheck = !mBranch && opcode != coreTypes::INT_SYS; // Result is unspecified otherwise.
        mNoCommit = opcode inside {coreTypes::ATOMIC_AMOADD_W, coreTypes::ATOMIC_AMOXOR_W,
                                   coreTypes::ATOMIC_AMOOR_W, coreTypes::ATOMIC_AMOAND_W,
                                   coreTypes::ATOMIC_AMOMAX_W, coreTypes::ATOMIC_AMOMAXU_W,
                                   coreTypes::ATOMIC_AMOMIN_W, coreTypes::ATOMIC_AMOMINU_W};
        case (opcode)
            coreTypes::INT_BEQ: mTaken = srcA == srcB;
            coreTypes::INT_BNE: mTaken = srcA != srcB;
            coreTypes::INT_BLT: mTaken = $signed(srcA) < $signed(srcB);
            coreTypes::INT_BGE: mTaken = $signed(srcA) >= $signed(srcB);
            coreTypes::INT_BLTU: mTaken = srcA < srcB;
            default: mTaken = srcA >= srcB;
        endcase
        mFlags = 4'd0;
        mHist = history;
        mRetIdx = retIdx;
        mRedirect = 0;
        mBt = 0;
        mCall = 0;
        mDst = link;
        if (opcode == coreTypes::INT_V_RET) actual = srcA & ~32'd1;
        else actual = (srcA + 32'($signed(imm[11:0]))) & ~32'd1;
        if (mBranch) begin
            mFlags = predValid ? (mTaken ? 4'd2 : 4'd3) : 4'd1;
            mHist = {history[histBits-2:0], mTaken};
            mRedirect = mTaken != predTaken;
            mBt = mTaken && !predValid;
            if (mTaken) mDst = pc + 32'($signed(imm[12:0]));
        end else if (mJump) begin
            mRedirect = actual[31:1] != srcB[31:1];
            mDst = actual;
            mCall = opcode == coreTypes::INT_V_JALR;
            mBt = mRedirect && opcode != coreTypes::INT_V_RET;
            if (mRedirect && opcode == coreTypes::INT_V_RET) mRetIdx = retIdx - 1;
            if (mRedirect && mCall) mRetIdx = retIdx + 1;
        end else if (opcode == coreTypes::INT_SYS) begin
            mFlags = imm[3:0];
        end
    end

    always_ff @(posedge clk) begin
        expValid <= rst && mAccept;
        expBr <= rst && mAccept && mRedirect;
        expBt <= rst && mAccept && mBt;
        expCheck <= mCheck;
        expResult <= mResult;
        expTag <= tagDst;
        expSqN <= sqN;
        expStoreSqN <= storeSqN;
        expFlags <= mFlags;
        expNoCommit <= mNoCommit;
        expHist <= mHist;
        expRetIdx <= mRetIdx;
        expDst <= mDst;
        expSrc <= compressed ? pc : pc + 32'd2;
        expJump <= mJump;
        expCall <= mCall;
        expComp <= compressed;
    end

    // ##################################################
    // Checks
    // ##################################################

    assert property (@(posedge clk) disable iff (!rst)
        resValid == expValid && brTaken == expBr && btValid == expBt)
        else begin
            errCount++;
            $error("[FAIL] %0t valid, redirect or BTB strobe wrong", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) expValid |->
        (!expCheck || resResult == expResult) && resNoCommit == expNoCommit)
        else begin
            errCount++;
            $error("[FAIL] %0t result %h, expected %h", $time, resResult, expResult);
        end

    assert property (@(posedge clk) disable iff (!rst) expValid |->
        resTag == expTag && resSqN == expSqN && resStoreSqN == expStoreSqN
        && resFlags == expFlags && brHistory == expHist && brRetIdx == expRetIdx)
        else begin
            errCount++;
            $error("[FAIL] %0t writeback fields or history wrong", $time);
        end

    assert property (@(posedge clk) disable iff (!rst) expBr |->
        brDstPC == expDst && brSqN == expSqN)
        else begin
            errCount++;
            $error("[FAIL] %0t redirect target %h, expected %h", $time, brDstPC, expDst);
        end

    assert property (@(posedge clk) disable iff (!rst) expBt |->
        btSrc == expSrc && btDst == expDst && btIsJump == expJump
        && btIsCall == expCall && btCompressed == expComp)
        else begin
            errCount++;
            $error("[FAIL] %0t BTB update wrong", $time);
        end

    assert property (@(posedge clk) disable iff (!rst)
        wbReq == (uopValid && en) && fwdValid == (wbReq && !tagDst[tagBits-1])
        && (!wbReq || (fwdTag == tagDst && (!mCheck || fwdResult == mResult))))
        else begin
            errCount++;
            $error("[FAIL] %0t forwarding wrong", $time);
        end

endmodule

//--- sim/intExecTb.sv
`timescale 1ns/1ps

module intExecTb;

    logic clk, rst, uopValid, compressed, predValid, predTaken, en, wbStall, invalidate;
    coreTypes::IntOp opcode;
    logic [31:0] srcA, srcB, imm, pc;
    logic [6:0] tagDst, sqN, storeSqN, invalidateSqN;
    logic [7:0] history;
    logic [3:0] retIdx;
    logic wbReq, fwdValid, resValid, resNoCommit, brTaken, btValid;
    logic btIsJump, btIsCall, btCompressed;
    logic [6:0] fwdTag, resTag, resSqN, resStoreSqN, brSqN;
    logic [31:0] fwdResult, resResult, brDstPC, btSrc, btDst;
    coreTypes::Flags resFlags;
    logic [7:0] brHistory;
    logic [3:0] brRetIdx;

    int seed = 7;
    int cycles = 0;
    logic [31:0] corner [3] = '{32'h0, 32'hffff_ffff, 32'h8000_0000};
    logic [31:0] a, tgt, ofs;

    intExecPort dut0 (.*);

    bind intAlu intExecTb_assert #(
        .tagBits(tagBits), .sqnBits(sqnBits), .histBits(histBits), .retIdxBits(retIdxBits)
    ) chk0 (.*);

    initial begin
        clk = 0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= 2000) begin
            $display(">>> FAIL");
            $fatal(1, "timeout: test did not finish");
        end
        if (dut0.alu0.chk0.errCount != 0) begin
            $display(">>> FAIL");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

    task automatic issue(input int op, input logic [31:0] va, vb, vi, input logic comp,
                         input logic pv, pt, stall, inv, input logic [6:0] sq, invSq);
        @(posedge clk);
        uopValid <= 1'b1;
        opcode <= coreTypes::IntOp'(op);
        srcA <= va;
        srcB <= vb;
        imm <= vi;
        pc <= $random(seed) & 32'hffff_fffe;
        compressed <= comp;
        tagDst <= $random(seed);
        sqN <= sq;
        storeSqN <= $random(seed);
        history <= $random(seed);
        retIdx <= $random(seed);
        predValid <= pv;
        predTaken <= pt;
        wbStall <= stall;
        invalidate <= inv;
        invalidateSqN <= invSq;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            uopValid <= 1'b0;
            wbStall <= 1'b0;
            invalidate <= 1'b0;
        end
    endtask

    initial begin
        rst = 0;
        uopValid = 0;
        opcode = coreTypes::INT_ADD;
        {srcA, srcB, imm, pc} = '0;
        {compressed, predValid, predTaken, wbStall, invalidate} = '0;
        {tagDst, sqN, storeSqN, invalidateSqN, history, retIdx} = '0;
        en = 1;
        repeat (8) @(posedge clk);
        rst <= 1'b1;
        idle(4);

        // ##################################################
        // ALU, bit manipulation, JAL, atomics and SYS
        // ##################################################
        for (int op = 0; op <= int'(coreTypes::ATOMIC_AMOMINU_W); op++) begin
            if (op >= int'(coreTypes::INT_BEQ) && op <= int'(coreTypes::INT_V_RET)
                && op != int'(coreTypes::INT_JAL)) continue;
            for (int k = 0; k < 3; k++) begin
                issue(op, corner[k], corner[(k + 1) % 3], $random(seed), 0, 0, 0, 0, 0,
                      $random(seed), 0);
            end
            repeat (7) begin
                issue(op, $random(seed), $random(seed), $random(seed), $random(seed), 0, 0,
                      0, 0, $random(seed), 0);
            end
        end
        idle(2);

        // Conditional branches, every prediction case, half with equal operands.
        for (int op = int'(coreTypes::INT_BEQ); op <= int'(coreTypes::INT_BGEU); op++) begin
            for (int j = 0; j < 16; j++) begin
                a = $random(seed);
                issue(op, a, j[0] ? a : $random(seed), $random(seed), j[1], j[2], j[3],
                      0, 0, $random(seed), 0);
            end
        end
        idle(2);

        // Indirect jumps with right and wrong predicted targets.
        for (int op = int'(coreTypes::INT_V_JR); op <= int'(coreTypes::INT_V_RET); op++) begin
            for (int j = 0; j < 16; j++) begin
                a = $random(seed);
                ofs = $random(seed);
                if (op == int'(coreTypes::INT_V_RET)) tgt = a;
                else tgt = a + {{20{ofs[11]}}, ofs[11:0]};
                issue(op, a, j[0] ? (tgt ^ 32'h10) : (tgt | j[2]), ofs, j[1], 0, 0, 0, 0,
                      $random(seed), 0);
            end
        end
        idle(2);

        // ##################################################
        // Stall, enable and invalidate
        // ##################################################
        repeat (8) begin
            issue(0, $random(seed), $random(seed), 0, 0, 0, 0, 1, 0, $random(seed), 0);
        end
        for (int d = -4; d <= 4; d++) begin
            issue(0, $random(seed), $random(seed), 0, 0, 0, 0, 0, 1, 7'(126 + d), 7'd126);
            issue(0, $random(seed), $random(seed), 0, 0, 0, 0, 0, 1, 7'(1 + d), 7'd1);
        end
        issue(0, 1, 2, 0, 0, 0, 0, 0, 0, 5, 0);
        en <= 1'b0;
        idle(3);
        en <= 1'b1;
        idle(4);

        if (dut0.alu0.chk0.errCount == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display(">>> FAIL");
            $fatal(1, "an assertion on the DUT outputs failed");
        end
    end

endmodule

//--- verilog.f
source/coreTypes.sv
source/leadZeroCount.sv
source/popCount.sv
source/intAlu.sv
source/intExecPort.sv
sim/intExecTb_assert.sv
sim/intExecTb.sv

//--- run.sh
#!/bin/sh
# Build and run the integer execute port testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
    --top-module intExecTb -f verilog.f -o simv
./obj_dir/simv
